// File: hw/lat_qos_pkg.sv
// Latency QoS throttle shared definitions
// Configuration word layout, request strobe and line-delta types

package lat_qos_pkg;

    // Width of the epoch cycle count
    localparam int EPOCH_BITS = 15;

    // Credit limit never drops below this
    localparam int MIN_LINE_CREDITS = 32;

    // Increment lock counter, locked while the top bit is set (8 epochs)
    localparam int INCR_LOCK_BITS = 4;

    // Largest multi-line request, coded as cl_len 0..3
    localparam int MAX_MULTI_LINE = 4;

    // One read request strobe, line count is cl_len + 1
    typedef struct packed {
        logic                              valid;
        logic [$clog2(MAX_MULTI_LINE)-1:0] cl_len;
    } rd_req_t;

    // Signed change in outstanding lines over one cycle
    typedef logic signed [$clog2(MAX_MULTI_LINE+1)+1:0] line_upd_t;

    // ==================================================
    // Configuration word, bit 0 is rd_enable
    // Write fields are reserved and ignored
    // ==================================================
    typedef struct packed {
        logic [15:0] wr_epoch_cycles;
        logic [15:0] rd_epoch_cycles;
        logic [14:0] wr_max_lines;
        logic [14:0] rd_max_lines;
        logic        wr_enable;
        logic        rd_enable;
    } cfg_word_t;

    // Live read-channel configuration seen by the datapath
    typedef struct packed {
        logic                  enable;
        logic [15:0]           max_lines;
        logic [EPOCH_BITS-1:0] epoch_cycles;
    } qos_cfg_t;

endpackage

// File: hw/lat_qos_cfg_ctrl.sv
// Latency QoS configuration control
// Holds the live read-channel settings and issues a reload strobe after each write

`timescale 1ns/1ps

module lat_qos_cfg_ctrl
    import lat_qos_pkg::*;
#(
    parameter int MAX_ACTIVE_LINES = 128
)
(
    input  logic      clk,
    input  logic      reset,

    // Configuration write, single-cycle strobe
    input  logic      cfg_valid,
    input  cfg_word_t cfg,

    // Live configuration toward the datapath
    output qos_cfg_t  qos,

    // Restart of the datapath counters, one cycle after the write
    output logic      reload
);

    // Default settings applied out of reset
    localparam qos_cfg_t QOS_DEFAULT = '{
        enable:       1'b1,
        max_lines:    16'(MAX_ACTIVE_LINES),
        epoch_cycles: EPOCH_BITS'(63)
    };

    // ==================================================
    // Configuration register
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            qos <= QOS_DEFAULT;
        end
        else if (cfg_valid)
        begin
            // Only the read fields are live
            qos.enable       <= cfg.rd_enable;
            // Zero-extend the 15-bit field
            qos.max_lines    <= {1'b0, cfg.rd_max_lines};
            // Top bit of the epoch field is unused
            qos.epoch_cycles <= cfg.rd_epoch_cycles[EPOCH_BITS-1:0];
        end
    end

    // ==================================================
    // Reload strobe
    // ==================================================

    // Delayed so qos already holds the new value when reload fires
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload <= 1'b0;
        end
        else
        begin
            reload <= cfg_valid;
        end
    end

endmodule

// File: hw/lat_qos_epoch_timer.sv
// Latency QoS epoch timer
// Down-counter giving one new_epoch pulse every epoch_cycles + 2 cycles

`timescale 1ns/1ps

module lat_qos_epoch_timer
    import lat_qos_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // Epoch length, reloaded at every underflow
    input  logic [EPOCH_BITS-1:0] epoch_cycles,

    // One cycle high per epoch
    output logic                  new_epoch
);

    // Extra top bit catches the underflow
    logic [EPOCH_BITS:0] epoch_cnt;

    // Underflow marks the epoch boundary
    assign new_epoch = epoch_cnt[EPOCH_BITS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Zero here underflows on the next cycle, so the first epoch is short
            epoch_cnt <= '0;
        end
        else if (new_epoch)
        begin
            epoch_cnt <= {1'b0, epoch_cycles};
        end
        else
        begin
            epoch_cnt <= epoch_cnt - 1'b1;
        end
    end

endmodule

// File: hw/lat_qos_line_tracker.sv
// Latency QoS outstanding line tracker
// Registers the per-cycle line delta and accumulates it into the active count

`timescale 1ns/1ps

module lat_qos_line_tracker
    import lat_qos_pkg::*;
#(
    parameter int MAX_ACTIVE_LINES = 128
)
(
    input  logic                                clk,
    input  logic                                reset,

    // Clears the count after a configuration write
    input  logic                                reload,

    // New read request, cl_len + 1 lines
    input  rd_req_t                             rd_req,

    // One line returned
    input  logic                                rsp_valid,

    // Lines still outstanding
    output logic [$clog2(MAX_ACTIVE_LINES+1):0] active_lines
);

    // Extra bit absorbs overshoot past the credit limit
    localparam int LINE_BITS = $clog2(MAX_ACTIVE_LINES+1) + 1;
    localparam int UPD_BITS  = $bits(line_upd_t);

    line_upd_t            req_lines;
    line_upd_t            rsp_lines;
    line_upd_t            line_upd_q;
    logic [LINE_BITS-1:0] line_upd_ext;

    // ==================================================
    // Per-cycle delta
    // ==================================================

    always_comb
    begin
        req_lines = '0;
        rsp_lines = '0;

        if (rd_req.valid)
        begin
            // Multi-line request
            req_lines = line_upd_t'(rd_req.cl_len) + line_upd_t'(1);
        end

        if (rsp_valid)
        begin
            // Responses always carry a single line
            rsp_lines = line_upd_t'(1);
        end
    end

    // Pipeline stage between the strobes and the accumulator
    always_ff @(posedge clk)
    begin
        if (reset || reload)
        begin
            line_upd_q <= '0;
        end
        else
        begin
            line_upd_q <= req_lines - rsp_lines;
        end
    end

    // ==================================================
    // Accumulator
    // ==================================================

    // Sign-extend up to the counter width
    assign line_upd_ext = {{(LINE_BITS-UPD_BITS){line_upd_q[UPD_BITS-1]}}, line_upd_q};

    always_ff @(posedge clk)
    begin
        if (reset || reload)
        begin
            active_lines <= '0;
        end
        else
        begin
            active_lines <= active_lines + line_upd_ext;
        end
    end

endmodule

// File: hw/lat_qos_credit_limiter.sv
// Latency QoS credit limiter
// Adapts the read credit limit per epoch and raises almost-full at the limit

`timescale 1ns/1ps

module lat_qos_credit_limiter
    import lat_qos_pkg::*;
#(
    parameter int MAX_ACTIVE_LINES = 128
)
(
    input  logic                                clk,
    input  logic                                reset,

    // Reloads the limit from max_lines
    input  logic                                reload,

    // Throttling enabled
    input  logic                                enable,

    // Configured ceiling of the limit
    input  logic [15:0]                         max_lines,

    // Epoch boundary pulse
    input  logic                                new_epoch,

    // Lines still outstanding
    input  logic [$clog2(MAX_ACTIVE_LINES+1):0] active_lines,

    // Fabric almost-full, level
    input  logic                                fiu_almost_full,

    // Almost-full toward the request source
    output logic                                afu_almost_full
);

    localparam int LINE_BITS = $clog2(MAX_ACTIVE_LINES+1) + 1;

    logic [LINE_BITS-1:0]      credit_limit;
    logic                      throttle;
    logic                      throttle_fired;
    logic                      fiu_was_full;
    logic                      decr_done;
    logic                      credits_at_min;
    logic                      credits_at_max;
    logic                      do_decr;
    logic                      do_incr;
    logic [INCR_LOCK_BITS-1:0] incr_lock_cnt;
    logic                      incr_locked;

    // Fabric almost-full passes straight through
    assign afu_almost_full = fiu_almost_full || throttle;

    // ==================================================
    // Throttle
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset || reload)
        begin
            throttle <= 1'b0;
        end
        else
        begin
            throttle <= enable && (active_lines >= credit_limit);
        end
    end

    // ==================================================
    // Per-epoch history
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset || reload || new_epoch)
        begin
            throttle_fired <= 1'b0;
            fiu_was_full   <= 1'b0;
            decr_done      <= 1'b0;
        end
        else
        begin
            // Sticky until the next boundary
            if (throttle)
            begin
                throttle_fired <= 1'b1;
            end
            if (fiu_almost_full)
            begin
                fiu_was_full <= 1'b1;
            end
            if (do_decr)
            begin
                decr_done <= 1'b1;
            end
        end
    end

    // ==================================================
    // Increment lock
    // ==================================================

    // Locked while the top bit is set
    assign incr_locked = incr_lock_cnt[INCR_LOCK_BITS-1];

    // Survives reload so a config write cannot bypass the lockout
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            incr_lock_cnt <= '0;
        end
        else if (do_decr)
        begin
            // Restart the lockout
            incr_lock_cnt <= '1;
        end
        else if (new_epoch && incr_locked)
        begin
            incr_lock_cnt <= incr_lock_cnt - 1'b1;
        end
    end

    // ==================================================
    // Limit adaptation
    // ==================================================

    assign credits_at_min = credit_limit <= LINE_BITS'(MIN_LINE_CREDITS);
    // Compare at the config width since max_lines may be wider
    assign credits_at_max = 16'(credit_limit) >= max_lines;

    // Step down once per epoch while the fabric is full
    assign do_decr = fiu_was_full && !decr_done && !credits_at_min;

    // Step up at the boundary after a quiet epoch in which we throttled
    assign do_incr = new_epoch && throttle_fired && !fiu_was_full &&
                     !incr_locked && !credits_at_max;

    always_ff @(posedge clk)
    begin
        if (reset || reload)
        begin
            credit_limit <= LINE_BITS'(max_lines);
        end
        else if (do_decr)
        begin
            credit_limit <= credit_limit - 1'b1;
        end
        else if (do_incr)
        begin
            credit_limit <= credit_limit + 1'b1;
        end
    end

endmodule

// File: hw/lat_qos_throttle.sv
// Latency QoS read throttle, top level
// Ties config control, epoch timer, line tracker and credit limiter together

`timescale 1ns/1ps

module lat_qos_throttle
    import lat_qos_pkg::*;
#(
    parameter int MAX_ACTIVE_LINES = 128
)
(
    input  logic      clk,
    input  logic      reset,

    // Configuration write
    input  logic      cfg_valid,
    input  cfg_word_t cfg,

    // Read traffic strobes
    input  rd_req_t   rd_req,
    input  logic      rsp_valid,

    // Fabric and source almost-full
    input  logic      fiu_almost_full,
    output logic      afu_almost_full
);

    localparam int LINE_BITS = $clog2(MAX_ACTIVE_LINES+1) + 1;

    qos_cfg_t             qos;
    logic                 reload;
    logic                 new_epoch;
    logic [LINE_BITS-1:0] active_lines;

    // ==================================================
    // Configuration
    // ==================================================

    lat_qos_cfg_ctrl #(
        .MAX_ACTIVE_LINES (MAX_ACTIVE_LINES)
    ) u_cfg_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cfg_valid (cfg_valid),
        .cfg       (cfg),
        .qos       (qos),
        .reload    (reload)
    );

    // Sampling epochs
    lat_qos_epoch_timer u_epoch_timer (
        .clk          (clk),
        .reset        (reset),
        .epoch_cycles (qos.epoch_cycles),
        .new_epoch    (new_epoch)
    );

    // ==================================================
    // Datapath
    // ==================================================

    lat_qos_line_tracker #(
        .MAX_ACTIVE_LINES (MAX_ACTIVE_LINES)
    ) u_line_tracker (
        .clk          (clk),
        .reset        (reset),
        .reload       (reload),
        .rd_req       (rd_req),
        .rsp_valid    (rsp_valid),
        .active_lines (active_lines)
    );

    lat_qos_credit_limiter #(
        .MAX_ACTIVE_LINES (MAX_ACTIVE_LINES)
    ) u_credit_limiter (
        .clk             (clk),
        .reset           (reset),
        .reload          (reload),
        .enable          (qos.enable),
        .max_lines       (qos.max_lines),
        .new_epoch       (new_epoch),
        .active_lines    (active_lines),
        .fiu_almost_full (fiu_almost_full),
        .afu_almost_full (afu_almost_full)
    );

endmodule

// File: test/lat_qos_tb.sv
// Latency QoS throttle testbench
// Random read traffic checked by concurrent assertions against a line-count model

`timescale 1ns/1ps

module lat_qos_tb
    import lat_qos_pkg::*;
();

    localparam int MAX_ACTIVE_LINES = 128;
    // epoch_cycles of 30 gives 32-cycle epochs
    localparam int EPOCH_LEN    = 32;
    localparam int K_EPOCHS     = 4;
    localparam int FLOOR_EPOCHS = 20;
    // Six phases where the two fabric holds dominate
    localparam int RUN_CYCLES = 100 + 150 + 150 + (K_EPOCHS * EPOCH_LEN + 150) +
                                (FLOOR_EPOCHS * EPOCH_LEN + 150) + 150;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES * 12 / 10;

    logic      clk;
    logic      reset;
    logic      cfg_valid;
    cfg_word_t cfg;
    rd_req_t   rd_req;
    logic      rsp_valid;
    logic      fiu_almost_full;
    logic      afu_almost_full;

    integer seed;
    int     errors = 0;
    int     cycles = 0;
    int     model_lines;
    int     lines_q [0:1];
    // Window the credit limit must lie in
    // Both ends are equal when the limit is known exactly
    int     lim_lo;
    int     lim_hi;

    lat_qos_throttle #(
        .MAX_ACTIVE_LINES (MAX_ACTIVE_LINES)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .cfg_valid       (cfg_valid),
        .cfg             (cfg),
        .rd_req          (rd_req),
        .rsp_valid       (rsp_valid),
        .fiu_almost_full (fiu_almost_full),
        .afu_almost_full (afu_almost_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Reference model of outstanding lines
    // ==================================================

    // Count after each edge and two stages of delay to line up with the registered throttle
    always @(posedge clk)
    begin
        if (reset)
        begin
            model_lines <= 0;
            lines_q[0]  <= 0;
            lines_q[1]  <= 0;
        end
        else
        begin
            // A config write clears the count
            // No traffic runs around a config write
            if (cfg_valid)
                model_lines <= 0;
            else
                model_lines <= model_lines + (rd_req.valid ? int'(rd_req.cl_len) + 1 : 0) -
                               (rsp_valid ? 1 : 0);
            lines_q[0] <= model_lines;
            lines_q[1] <= lines_q[0];
        end
    end

    // ==================================================
    // Assertions
    // ==================================================

    // Fabric almost-full passes through in the same cycle
    a_passthrough: assert property (@(posedge clk) disable iff (reset)
        fiu_almost_full |-> afu_almost_full)
    else
    begin
        errors++;
        $display("CHECK FAILED afu_almost_full got %h expected %h",
                 $sampled(afu_almost_full), 1'b1);
    end

    // Below the lowest possible limit there is no throttle
    a_no_throttle: assert property (@(posedge clk) disable iff (reset)
        (!fiu_almost_full && lines_q[1] < lim_lo) |-> !afu_almost_full)
    else
    begin
        errors++;
        $display("CHECK FAILED afu_almost_full got %h expected %h lines %h",
                 $sampled(afu_almost_full), 1'b0, $sampled(lines_q[1]));
    end

    // At or above the highest possible limit the throttle is on
    a_throttle: assert property (@(posedge clk) disable iff (reset)
        (!fiu_almost_full && lines_q[1] >= lim_hi) |-> afu_almost_full)
    else
    begin
        errors++;
        $display("CHECK FAILED afu_almost_full got %h expected %h lines %h",
                 $sampled(afu_almost_full), 1'b1, $sampled(lines_q[1]));
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_cfg(input logic en, input int max_lines, input int epoch_cycles);
        next_cycle();
        cfg                 = '0;
        cfg.rd_enable       = en;
        cfg.rd_max_lines    = 15'(max_lines);
        cfg.rd_epoch_cycles = 16'(epoch_cycles);
        // Junk in the reserved write fields
        cfg.wr_enable       = 1'b1;
        cfg.wr_max_lines    = 15'h1234;
        cfg.wr_epoch_cycles = 16'h0005;
        cfg_valid           = 1'b1;
        next_cycle();
        cfg_valid = 1'b0;
        repeat (3) next_cycle();
    endtask

    // Random sizes first and single lines at the end to land on target exactly
    task automatic fill_to(input int target);
        int cl_len;
        while (model_lines < target)
        begin
            if (model_lines + MAX_MULTI_LINE < target)
                cl_len = $unsigned($random(seed)) % MAX_MULTI_LINE;
            else
                cl_len = 0;
            rd_req.valid  = 1'b1;
            rd_req.cl_len = 2'(cl_len);
            next_cycle();
        end
        rd_req = '0;
    endtask

    task automatic drain_to(input int target);
        while (model_lines > target)
        begin
            rsp_valid = 1'b1;
            next_cycle();
        end
        rsp_valid = 1'b0;
    endtask

    task automatic wait_for_throttle(input int lines);
        int waited;
        waited = 0;
        while (!afu_almost_full && waited < 8)
        begin
            next_cycle();
            waited++;
        end
        if (!afu_almost_full)
        begin
            errors++;
            $display("Throttle never rose with %0d lines outstanding", lines);
        end
        repeat (2) next_cycle();
    endtask

    task automatic hold_fabric_full(input int epochs);
        fiu_almost_full = 1'b1;
        repeat (epochs * EPOCH_LEN) next_cycle();
        fiu_almost_full = 1'b0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        seed            = 32'h8e2695f7;
        reset           = 1'b1;
        cfg_valid       = 1'b0;
        cfg             = '0;
        rd_req          = '0;
        rsp_valid       = 1'b0;
        fiu_almost_full = 1'b0;
        lim_lo          = MAX_ACTIVE_LINES;
        lim_hi          = MAX_ACTIVE_LINES;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle and then random fabric toggles that pass straight through
        repeat (20) next_cycle();
        repeat (60)
        begin
            fiu_almost_full = 1'($random(seed));
            next_cycle();
        end
        fiu_almost_full = 1'b0;
        repeat (5) next_cycle();

        // Limit stays at max_lines while the fabric is quiet
        write_cfg(1'b1, 40, 30);
        lim_lo = 40;
        lim_hi = 40;
        fill_to(40);
        wait_for_throttle(40);
        drain_to(0);
        repeat (5) next_cycle();

        // No throttle at any count while disabled
        write_cfg(1'b0, 40, 30);
        lim_lo = 1024;
        lim_hi = 1024;
        fill_to(60);
        repeat (6) next_cycle();
        drain_to(0);
        repeat (5) next_cycle();

        // One step down per epoch of fabric almost-full
        write_cfg(1'b1, 40, 30);
        lim_lo = (40 - K_EPOCHS - 1 > MIN_LINE_CREDITS) ? 40 - K_EPOCHS - 1 : MIN_LINE_CREDITS;
        lim_hi = 39;
        hold_fabric_full(K_EPOCHS);
        fill_to(39);
        wait_for_throttle(39);
        drain_to(0);
        repeat (5) next_cycle();

        // Long hold drives the limit onto the floor
        hold_fabric_full(FLOOR_EPOCHS);
        lim_lo = MIN_LINE_CREDITS;
        lim_hi = MIN_LINE_CREDITS;
        fill_to(MIN_LINE_CREDITS);
        wait_for_throttle(MIN_LINE_CREDITS);
        drain_to(0);
        repeat (5) next_cycle();

        // New config with lines still outstanding clears the count and reloads the limit
        lim_hi = 40;
        fill_to(20);
        write_cfg(1'b1, 50, 30);
        lim_lo = 50;
        lim_hi = 50;
        fill_to(50);
        wait_for_throttle(50);
        drain_to(0);
        repeat (5) next_cycle();

        $display("Summary: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Cycle limit
    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: sim.f
hw/lat_qos_pkg.sv
hw/lat_qos_cfg_ctrl.sv
hw/lat_qos_epoch_timer.sv
hw/lat_qos_line_tracker.sv
hw/lat_qos_credit_limiter.sv
hw/lat_qos_throttle.sv
test/lat_qos_tb.sv
